// File: common/icache_pkg.sv
package icache_pkg;

	// command on the processor and memory buses
	typedef enum logic [1:0]
	{
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command;

	// memory transaction tag where zero means no transaction
	localparam int MEM_TAG_W = 4;

	// one cache line is one 64-bit word
	localparam int LINE_W = 64;

	// byte offset bits below the index
	localparam int BLOCK_OFFSET = 3;

endpackage

// File: icache/icache_controller.sv
module icache_controller #(
	parameter int INDEX_W = 5,
	localparam int TAG_W = 64 - icache_pkg::BLOCK_OFFSET - INDEX_W
) (
	// only the checker below uses the clock and reset
	input  logic                               clock,
	input  logic                               rst_n,

	// from memory
	input  logic [icache_pkg::MEM_TAG_W-1:0]   imem2proc_response,
	input  logic [icache_pkg::MEM_TAG_W-1:0]   imem2proc_tag,

	// from processor
	input  logic [63:0]                        proc2icache_addr,
	input  icache_pkg::bus_command             proc2icache_command,

	// from cache arrays
	input  logic [icache_pkg::LINE_W-1:0]      cachemem_data,
	input  logic                               cachemem_valid,
	input  logic                               cachemem_is_miss,

	// from miss table
	input  logic                               table_full,
	input  logic                               table_pending,

	// to memory
	output icache_pkg::bus_command             proc2imem_command,
	output logic [63:0]                        proc2imem_addr,

	// to processor
	output logic [icache_pkg::LINE_W-1:0]      icache_data_out,
	output logic                               icache_data_valid,
	output logic [icache_pkg::MEM_TAG_W-1:0]   icache2proc_response,
	output logic [icache_pkg::MEM_TAG_W-1:0]   icache2proc_tag,

	// to cache arrays and miss table
	output logic [INDEX_W-1:0]                 index,
	output logic [TAG_W-1:0]                   tag,
	output logic                               read_enable,
	output logic                               alloc
);
	import icache_pkg::*;

	logic line_hit;

	assign {tag, index} = proc2icache_addr[63:BLOCK_OFFSET];

	// a line is only usable when present and the tag agrees
	assign line_hit = cachemem_valid && !cachemem_is_miss;

	always_comb
	begin
		proc2imem_command    = BUS_NONE;
		proc2imem_addr       = '0;
		icache_data_out      = cachemem_data;
		icache_data_valid    = 1'b0;
		icache2proc_response = imem2proc_response;
		icache2proc_tag      = imem2proc_tag;
		read_enable          = 1'b0;
		alloc                = 1'b0;

		case (proc2icache_command)
			BUS_LOAD:
			begin
				read_enable = 1'b1;
				if (line_hit)
				begin
					icache_data_valid = 1'b1;
				end
				else if (!table_pending && !table_full)
				begin
					// new miss requests the aligned line
					proc2imem_command = BUS_LOAD;
					proc2imem_addr    = {proc2icache_addr[63:BLOCK_OFFSET], {BLOCK_OFFSET{1'b0}}};
					// zero response means memory was busy and the load repeats
					alloc             = (imem2proc_response != '0);
				end
				else
				begin
					// already outstanding or no room so nothing is issued
					icache2proc_response = '0;
				end
			end

			BUS_NONE:
			begin
				icache2proc_tag = '0;
			end

			default:
			begin
				// stores are not handled by the icache
				icache2proc_tag = '0;
				if (table_full)
					icache2proc_response = '0;
			end
		endcase
	end

	// once allocated, the held address must not issue a second load
	property p_alloc_recorded;
		@(posedge clock) disable iff (!rst_n)
		alloc ##1 (proc2icache_command == BUS_LOAD && $stable(proc2icache_addr))
			|-> (table_pending || line_hit);
	endproperty

	a_alloc_recorded: assert property (p_alloc_recorded)
		else $error("allocated miss not seen as pending on the next cycle");

endmodule

// File: icache/icache_mem.sv
module icache_mem #(
	parameter int INDEX_W = 5,
	localparam int TAG_W = 64 - icache_pkg::BLOCK_OFFSET - INDEX_W
) (
	input  logic                          clock,
	input  logic                          rst_n,

	// lookup port
	input  logic                          read_enable,
	input  logic [INDEX_W-1:0]            index,
	input  logic [TAG_W-1:0]              tag,

	// fill port
	input  logic                          fill,
	input  logic [INDEX_W-1:0]            fill_index,
	input  logic [TAG_W-1:0]              fill_tag,
	input  logic [icache_pkg::LINE_W-1:0] fill_data,

	output logic [icache_pkg::LINE_W-1:0] cachemem_data,
	output logic                          cachemem_valid,
	output logic                          cachemem_is_miss
);
	import icache_pkg::*;

	localparam int N_LINES = 1 << INDEX_W;

	logic [LINE_W-1:0]  data_array [N_LINES];
	logic [TAG_W-1:0]   tag_array  [N_LINES];
	logic [N_LINES-1:0] valid_bits;
	logic               tag_match;

	// combinational read of the addressed line
	assign tag_match        = (tag_array[index] == tag);
	assign cachemem_data    = data_array[index];
	assign cachemem_valid   = read_enable && valid_bits[index];
	assign cachemem_is_miss = read_enable && !(valid_bits[index] && tag_match);

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_bits <= '0;
		end
		else if (fill)
		begin
			valid_bits[fill_index] <= 1'b1;
		end
	end

	// a fill replaces whatever line sat at that index
	always_ff @(posedge clock)
	begin
		if (fill)
		begin
			data_array[fill_index] <= fill_data;
			tag_array[fill_index]  <= fill_tag;
		end
	end

	// a filled line must hit on the next lookup of the same address
	property p_fill_then_hit;
		@(posedge clock) disable iff (!rst_n)
		fill ##1 (read_enable && index == $past(fill_index) && tag == $past(fill_tag)
			&& !(fill && fill_index == index))
			|-> !cachemem_is_miss && cachemem_data == $past(fill_data);
	endproperty

	a_fill_then_hit: assert property (p_fill_then_hit)
		else $error("filled line does not hit on the following cycle");

endmodule

// File: icache/miss_table.sv
module miss_table #(
	parameter int INDEX_W = 5,
	parameter int N_MISS = 4,
	localparam int TAG_W = 64 - icache_pkg::BLOCK_OFFSET - INDEX_W
) (
	input  logic                             clock,
	input  logic                             rst_n,

	// new entry for an accepted load
	input  logic                             alloc,
	input  logic [icache_pkg::MEM_TAG_W-1:0] alloc_mem_tag,
	input  logic [INDEX_W-1:0]               alloc_index,
	input  logic [TAG_W-1:0]                 alloc_tag,

	// returning transaction
	input  logic [icache_pkg::MEM_TAG_W-1:0] imem2proc_tag,

	// current fetch
	input  logic [INDEX_W-1:0]               lookup_index,
	input  logic [TAG_W-1:0]                 lookup_tag,

	output logic                             full,
	output logic                             pending,
	output logic                             fill,
	output logic [INDEX_W-1:0]               fill_index,
	output logic [TAG_W-1:0]                 fill_tag
);
	import icache_pkg::*;

	localparam int SLOT_W = (N_MISS > 1) ? $clog2(N_MISS) : 1;
	localparam int CNT_W  = $clog2(N_MISS + 1);

	logic [N_MISS-1:0]    live;
	logic [MEM_TAG_W-1:0] ent_mem_tag [N_MISS];
	logic [INDEX_W-1:0]   ent_index   [N_MISS];
	logic [TAG_W-1:0]     ent_tag     [N_MISS];
	logic [CNT_W-1:0]     count;

	logic [N_MISS-1:0]    ret_match;
	logic [N_MISS-1:0]    tag_clash;
	logic [SLOT_W-1:0]    free_slot;

	always_comb
	begin
		logic found;
		found      = 1'b0;
		free_slot  = '0;
		pending    = 1'b0;
		fill_index = '0;
		fill_tag   = '0;
		for (int i = 0; i < N_MISS; i++)
		begin
			// tag 0 never names a transaction
			ret_match[i] = live[i] && (imem2proc_tag != '0) && (ent_mem_tag[i] == imem2proc_tag);
			tag_clash[i] = live[i] && (ent_mem_tag[i] == alloc_mem_tag);
			if (live[i] && ent_index[i] == lookup_index && ent_tag[i] == lookup_tag)
				pending = 1'b1;
			if (ret_match[i])
			begin
				fill_index = ent_index[i];
				fill_tag   = ent_tag[i];
			end
			if (!live[i] && !found)
			begin
				free_slot = SLOT_W'(i);
				found     = 1'b1;
			end
		end
	end

	assign fill = |ret_match;
	assign full = (count == CNT_W'(N_MISS));

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			live  <= '0;
			count <= '0;
		end
		else
		begin
			live <= live & ~ret_match;
			if (alloc)
				live[free_slot] <= 1'b1;
			count <= count + CNT_W'(alloc) - CNT_W'(fill);
		end
	end

	always_ff @(posedge clock)
	begin
		if (alloc)
		begin
			ent_mem_tag[free_slot] <= alloc_mem_tag;
			ent_index[free_slot]   <= alloc_index;
			ent_tag[free_slot]     <= alloc_tag;
		end
	end

	a_no_alloc_full: assert property (@(posedge clock) disable iff (!rst_n) alloc |-> !full)
		else $error("miss table allocated while full");

	a_unique_mem_tag: assert property (@(posedge clock) disable iff (!rst_n)
		alloc |-> !(|tag_clash))
		else $error("memory tag %0h already held by a live entry", alloc_mem_tag);

endmodule

// File: source/icache_top.sv
module icache_top #(
	parameter int INDEX_W = 5,
	parameter int N_MISS = 4
) (
	input  logic                             clock,
	input  logic                             rst_n,

	// processor side
	input  logic [63:0]                      proc2icache_addr,
	input  icache_pkg::bus_command           proc2icache_command,
	output logic [icache_pkg::LINE_W-1:0]    icache_data_out,
	output logic                             icache_data_valid,
	output logic [icache_pkg::MEM_TAG_W-1:0] icache2proc_response,
	output logic [icache_pkg::MEM_TAG_W-1:0] icache2proc_tag,

	// memory side
	output icache_pkg::bus_command           proc2imem_command,
	output logic [63:0]                      proc2imem_addr,
	input  logic [icache_pkg::MEM_TAG_W-1:0] imem2proc_response,
	input  logic [icache_pkg::MEM_TAG_W-1:0] imem2proc_tag,
	input  logic [icache_pkg::LINE_W-1:0]    imem2proc_data
);
	import icache_pkg::*;

	localparam int TAG_W = 64 - BLOCK_OFFSET - INDEX_W;

	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;
	logic               read_enable;
	logic               alloc;
	logic [LINE_W-1:0]  cachemem_data;
	logic               cachemem_valid;
	logic               cachemem_is_miss;
	logic               table_full;
	logic               table_pending;
	logic               fill;
	logic [INDEX_W-1:0] fill_index;
	logic [TAG_W-1:0]   fill_tag;

	icache_controller #(
		.INDEX_W(INDEX_W)
	) controller_i (
		.clock(clock),
		.rst_n(rst_n),
		.imem2proc_response(imem2proc_response),
		.imem2proc_tag(imem2proc_tag),
		.proc2icache_addr(proc2icache_addr),
		.proc2icache_command(proc2icache_command),
		.cachemem_data(cachemem_data),
		.cachemem_valid(cachemem_valid),
		.cachemem_is_miss(cachemem_is_miss),
		.table_full(table_full),
		.table_pending(table_pending),
		.proc2imem_command(proc2imem_command),
		.proc2imem_addr(proc2imem_addr),
		.icache_data_out(icache_data_out),
		.icache_data_valid(icache_data_valid),
		.icache2proc_response(icache2proc_response),
		.icache2proc_tag(icache2proc_tag),
		.index(index),
		.tag(tag),
		.read_enable(read_enable),
		.alloc(alloc)
	);

	icache_mem #(
		.INDEX_W(INDEX_W)
	) cachemem_i (
		.clock(clock),
		.rst_n(rst_n),
		.read_enable(read_enable),
		.index(index),
		.tag(tag),
		.fill(fill),
		.fill_index(fill_index),
		.fill_tag(fill_tag),
		.fill_data(imem2proc_data),
		.cachemem_data(cachemem_data),
		.cachemem_valid(cachemem_valid),
		.cachemem_is_miss(cachemem_is_miss)
	);

	// the accepted response tag names the new entry
	miss_table #(
		.INDEX_W(INDEX_W),
		.N_MISS(N_MISS)
	) miss_table_i (
		.clock(clock),
		.rst_n(rst_n),
		.alloc(alloc),
		.alloc_mem_tag(imem2proc_response),
		.alloc_index(index),
		.alloc_tag(tag),
		.imem2proc_tag(imem2proc_tag),
		.lookup_index(index),
		.lookup_tag(tag),
		.full(table_full),
		.pending(table_pending),
		.fill(fill),
		.fill_index(fill_index),
		.fill_tag(fill_tag)
	);

endmodule

// File: tb/mem_model.sv
module mem_model #(
	parameter int LATENCY = 6
) (
	input  logic                             clock,
	input  logic                             rst_n,
	// holds back every return while set
	input  logic                             hold,
	input  icache_pkg::bus_command           proc2imem_command,
	input  logic [63:0]                      proc2imem_addr,
	output logic [icache_pkg::MEM_TAG_W-1:0] imem2proc_response,
	output logic [icache_pkg::MEM_TAG_W-1:0] imem2proc_tag,
	output logic [icache_pkg::LINE_W-1:0]    imem2proc_data
);
	import icache_pkg::*;

	localparam int N_TAGS = 1 << MEM_TAG_W;

	logic [N_TAGS-1:0]    in_flight;
	logic [63:0]          req_addr [N_TAGS];
	int                   due      [N_TAGS];
	logic [MEM_TAG_W-1:0] next_tag;
	logic [MEM_TAG_W-1:0] ret_tag;
	int                   req_count;
	int                   cycle;

	// every fifth request finds memory busy
	assign imem2proc_response = (proc2imem_command == BUS_LOAD && req_count % 5 != 4)
		? next_tag : '0;

	// lowest due tag goes back first with one return per cycle
	always_comb
	begin
		ret_tag = '0;
		for (int t = N_TAGS - 1; t > 0; t--)
			if (!hold && in_flight[t] && due[t] <= cycle)
				ret_tag = MEM_TAG_W'(t);
	end

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			in_flight      <= '0;
			next_tag       <= MEM_TAG_W'(1);
			req_count      <= 0;
			cycle          <= 0;
			imem2proc_tag  <= '0;
			imem2proc_data <= '0;
		end
		else
		begin
			cycle          <= cycle + 1;
			imem2proc_tag  <= ret_tag;
			imem2proc_data <= '0;
			if (ret_tag != '0)
			begin
				in_flight[ret_tag] <= 1'b0;
				imem2proc_data     <= {req_addr[ret_tag][63:BLOCK_OFFSET], {BLOCK_OFFSET{1'b0}}}
					^ 64'h5A5A_5A5A_5A5A_5A5A;
			end
			if (proc2imem_command == BUS_LOAD)
			begin
				req_count <= req_count + 1;
				if (imem2proc_response != '0)
				begin
					in_flight[next_tag] <= 1'b1;
					req_addr[next_tag]  <= proc2imem_addr;
					// the output register adds the last cycle
					due[next_tag]       <= cycle + LATENCY - 1;
					if (next_tag == MEM_TAG_W'(N_TAGS - 1))
						next_tag <= MEM_TAG_W'(1);
					else
						next_tag <= next_tag + 1'b1;
				end
			end
		end
	end

endmodule

// File: tb/icache_tb.sv
module icache_tb;
	import icache_pkg::*;

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 8;
	localparam int INDEX_W       = 5;
	localparam int N_MISS        = 4;
	localparam int LATENCY       = 6;
	// worst miss covers busy retries and a full table plus the latency
	localparam int MISS_LIMIT    = 32;
	// fetches per test in test order
	localparam int TOTAL_FETCHES = 1 + 1 + 3 + 10 + 5 + 2;

	logic                 clock;
	logic                 rst_n;
	logic [63:0]          proc2icache_addr;
	bus_command           proc2icache_command;
	logic [LINE_W-1:0]    icache_data_out;
	logic                 icache_data_valid;
	logic [MEM_TAG_W-1:0] icache2proc_response;
	logic [MEM_TAG_W-1:0] icache2proc_tag;
	bus_command           proc2imem_command;
	logic [63:0]          proc2imem_addr;
	logic [MEM_TAG_W-1:0] imem2proc_response;
	logic [MEM_TAG_W-1:0] imem2proc_tag;
	logic [LINE_W-1:0]    imem2proc_data;
	logic                 hold;

	// what the current cycle must show
	logic expect_issue;
	logic expect_hit;
	logic expect_block;
	logic expect_idle;

	logic [63:0] aligned_addr;
	logic [63:0] expected_data;
	int          seed;
	int          errors;
	int          tests;
	int          busy_seen;
	int          idle_returns;

	icache_top #(
		.INDEX_W(INDEX_W),
		.N_MISS(N_MISS)
	) dut_i (.*);

	mem_model #(
		.LATENCY(LATENCY)
	) mem_i (.*);

	// memory rule for the 8-byte line of the fetched address
	assign aligned_addr  = proc2icache_addr & ~64'h7;
	assign expected_data = aligned_addr ^ 64'h5A5A_5A5A_5A5A_5A5A;

	always #(CLK_PERIOD / 2) clock = ~clock;

	always @(negedge clock)
	begin
		if (rst_n && proc2imem_command == BUS_LOAD && imem2proc_response == '0)
			busy_seen++;
		if (expect_idle && imem2proc_tag != '0)
			idle_returns++;
	end

	initial
	begin
		#(CLK_PERIOD * (RESET_CYCLES + TOTAL_FETCHES * MISS_LIMIT));
		$display("watchdog expired with the tests still running");
		$display("Regression failed");
		$finish;
	end

	task automatic note_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		errors++;
		$display("MISMATCH %s: got %h, expected %h at time %0t", name, got, want, $time);
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%s at time %0t", msg, $time);
	endtask

	a_issue: assert property (@(posedge clock) disable iff (!rst_n)
		expect_issue |-> proc2imem_command == BUS_LOAD)
		else note_mismatch("proc2imem_command", 64'($sampled(proc2imem_command)), 64'(BUS_LOAD));
	a_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		proc2imem_command == BUS_LOAD |-> proc2imem_addr == aligned_addr)
		else note_mismatch("proc2imem_addr", $sampled(proc2imem_addr), $sampled(aligned_addr));
	// the processor sees the memory's answer to an issued load
	a_response: assert property (@(posedge clock) disable iff (!rst_n)
		proc2imem_command == BUS_LOAD |-> icache2proc_response == imem2proc_response)
		else note_mismatch("icache2proc_response", 64'($sampled(icache2proc_response)),
			64'($sampled(imem2proc_response)));
	a_data: assert property (@(posedge clock) disable iff (!rst_n)
		icache_data_valid |-> icache_data_out == expected_data)
		else note_mismatch("icache_data_out", $sampled(icache_data_out), $sampled(expected_data));
	a_hit_valid: assert property (@(posedge clock) disable iff (!rst_n)
		expect_hit |-> icache_data_valid)
		else note_mismatch("icache_data_valid", 64'($sampled(icache_data_valid)), 64'(1));
	a_hit_quiet: assert property (@(posedge clock) disable iff (!rst_n)
		expect_hit |-> proc2imem_command == BUS_NONE)
		else note_mismatch("proc2imem_command", 64'($sampled(proc2imem_command)), 64'(BUS_NONE));
	a_blocked: assert property (@(posedge clock) disable iff (!rst_n)
		expect_block |-> proc2imem_command == BUS_NONE)
		else note_mismatch("proc2imem_command", 64'($sampled(proc2imem_command)), 64'(BUS_NONE));
	// a refused load comes back while the processor holds the address
	a_retry: assert property (@(posedge clock) disable iff (!rst_n)
		(proc2imem_command == BUS_LOAD && imem2proc_response == '0) |=>
		(proc2icache_command != BUS_LOAD || !$stable(proc2icache_addr)
			|| proc2imem_command == BUS_LOAD))
		else note_failure("busy BUS_LOAD was not repeated on the next cycle");
	a_idle_cmd: assert property (@(posedge clock) disable iff (!rst_n)
		expect_idle |-> proc2imem_command == BUS_NONE)
		else note_mismatch("proc2imem_command", 64'($sampled(proc2imem_command)), 64'(BUS_NONE));
	a_idle_tag: assert property (@(posedge clock) disable iff (!rst_n)
		expect_idle |-> icache2proc_tag == '0)
		else note_mismatch("icache2proc_tag", 64'($sampled(icache2proc_tag)), 64'(0));
	a_idle_valid: assert property (@(posedge clock) disable iff (!rst_n)
		expect_idle |-> !icache_data_valid)
		else note_mismatch("icache_data_valid", 64'($sampled(icache_data_valid)), 64'(0));

	function automatic logic [63:0] random_addr(input logic [INDEX_W-1:0] index);
		logic [63:0] addr;
		addr = {$random(seed), $random(seed)};
		addr[INDEX_W+BLOCK_OFFSET-1:BLOCK_OFFSET] = index;
		return addr;
	endfunction

	// hold a load until the line is delivered
	task automatic fetch(input logic [63:0] addr, input logic want_issue, input logic want_hit);
		int waited;
		waited = 0;
		@(posedge clock);
		proc2icache_addr    <= addr;
		proc2icache_command <= BUS_LOAD;
		expect_issue        <= want_issue;
		expect_hit          <= want_hit;
		@(negedge clock);
		while (!icache_data_valid && waited < MISS_LIMIT)
		begin
			@(posedge clock);
			expect_issue <= 1'b0;
			expect_hit   <= 1'b0;
			@(negedge clock);
			waited++;
		end
		if (!icache_data_valid)
			note_failure($sformatf("fetch of %h never returned data", addr));
		@(posedge clock);
		proc2icache_command <= BUS_NONE;
		expect_issue        <= 1'b0;
		expect_hit          <= 1'b0;
	endtask

	// returns in the cycle where memory takes the load
	task automatic issue_until_accepted(input logic [63:0] addr);
		int waited;
		waited = 0;
		@(posedge clock);
		proc2icache_addr    <= addr;
		proc2icache_command <= BUS_LOAD;
		@(negedge clock);
		while (!(proc2imem_command == BUS_LOAD && imem2proc_response != '0)
			&& waited < MISS_LIMIT)
		begin
			@(negedge clock);
			waited++;
		end
		if (waited == MISS_LIMIT)
			note_failure($sformatf("load of %h was never accepted by memory", addr));
	endtask

	task automatic finish_test(input string name, input int start_errors);
		@(negedge clock);
		tests++;
		if (errors == start_errors)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - start_errors);
	endtask

	initial
	begin
		logic [63:0] addr_a;
		logic [63:0] addr_b;
		logic [63:0] held_addr [N_MISS];
		logic [63:0] blocked_addr;
		int          start_errors;
		int          busy_before;

		seed                = 6348;
		errors              = 0;
		tests               = 0;
		busy_seen           = 0;
		idle_returns        = 0;
		clock               = 1'b0;
		rst_n               = 1'b0;
		proc2icache_addr    = '0;
		proc2icache_command = BUS_NONE;
		hold                = 1'b0;
		expect_issue        = 1'b0;
		expect_hit          = 1'b0;
		expect_block        = 1'b0;
		expect_idle         = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		rst_n <= 1'b1;

		start_errors = errors;
		addr_a = random_addr(INDEX_W'($random(seed)));
		fetch(addr_a, 1'b1, 1'b0);
		finish_test("cold miss", start_errors);

		start_errors = errors;
		fetch(addr_a, 1'b0, 1'b1);
		finish_test("hit after fill", start_errors);

		// two tags sharing index 3
		start_errors = errors;
		addr_a = random_addr(INDEX_W'(3));
		addr_b = random_addr(INDEX_W'(3));
		fetch(addr_a, 1'b1, 1'b0);
		fetch(addr_b, 1'b1, 1'b0);
		fetch(addr_a, 1'b1, 1'b0);
		finish_test("eviction", start_errors);

		// memory keeps every line back until the table is full
		start_errors = errors;
		@(posedge clock);
		hold <= 1'b1;
		for (int i = 0; i < N_MISS; i++)
		begin
			held_addr[i] = random_addr(INDEX_W'(8 + i));
			issue_until_accepted(held_addr[i]);
		end
		blocked_addr = random_addr(INDEX_W'(8 + N_MISS));
		@(posedge clock);
		proc2icache_addr    <= blocked_addr;
		proc2icache_command <= BUS_LOAD;
		expect_block        <= 1'b1;
		repeat (LATENCY + 2) @(posedge clock);
		expect_block <= 1'b0;
		hold         <= 1'b0;
		fetch(blocked_addr, 1'b0, 1'b0);
		for (int i = 0; i < N_MISS; i++)
			fetch(held_addr[i], 1'b0, 1'b1);
		finish_test("full miss table", start_errors);

		// five cold loads always meet one busy answer
		start_errors = errors;
		busy_before = busy_seen;
		for (int i = 0; i < 5; i++)
			fetch(random_addr(INDEX_W'($random(seed))), 1'b1, 1'b0);
		if (busy_seen == busy_before)
			note_failure("memory never answered busy during the retry test");
		finish_test("busy retry", start_errors);

		start_errors = errors;
		idle_returns = 0;
		issue_until_accepted(random_addr(INDEX_W'(20)));
		@(posedge clock);
		proc2icache_command <= BUS_NONE;
		expect_idle         <= 1'b1;
		repeat (LATENCY + 3) @(posedge clock);
		expect_idle <= 1'b0;
		if (idle_returns == 0)
			note_failure("no memory return arrived while the bus was idle");
		finish_test("idle bus", start_errors);

		$display("%0d tests run, %0d failed checks", tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: icache_sub.f
common/icache_pkg.sv
icache/icache_controller.sv
icache/icache_mem.sv
icache/miss_table.sv
source/icache_top.sv
tb/mem_model.sv
tb/icache_tb.sv

// File: Makefile
TOP = icache_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f icache_sub.f

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
